// ==== hdl/boardStore.sv ====
`include "tetris_defs.svh"

module boardStore (
    input  logic               clk,
    input  logic               rst,
    input  logic               lock,
    input  logic               clearEn,
    input  tetrisPkg::boardT   pieceMask,
    output tetrisPkg::boardT   board,
    output logic               anyFull,
    output tetrisPkg::lineCntT lines
);

    import tetrisPkg::*;

    logic [`BOARD_ROWS-1:0] fullRow;
    rowIdxT                 clearIdx;   // Lowest full row
    boardT                  collapsed;

    always_comb begin
        clearIdx = '0;
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            fullRow[r] = &board[r];
            if (fullRow[r]) begin
                clearIdx = rowIdxT'(r);     // Later rows sit lower and win
            end
        end
    end

    assign anyFull = |fullRow;

    // Rows at and above the cleared one drop by one
    always_comb begin
        collapsed = board;
        for (int r = 1; r < `BOARD_ROWS; r++) begin
            if (rowIdxT'(r) <= clearIdx) begin
                collapsed[r] = board[r-1];
            end
        end
        collapsed[0] = '0;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            board <= '0;
            lines <= '0;
        end else if (lock) begin
            board <= board | pieceMask;
        end else if (clearEn && anyFull) begin
            board <= collapsed;
            lines <= lines + lineCntT'(1);
        end
    end

endmodule

// ==== hdl/gameControl.sv ====
module gameControl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic landed,
    input  logic spawnBlocked,
    input  logic anyFull,
    output logic spawn,
    output logic fallEn,
    output logic lock,
    output logic clearEn,
    output logic pieceDone,
    output logic gameOver
);

    import tetrisPkg::*;

    gameStateT state;
    gameStateT stateNext;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (start) begin
                    stateNext = SPAWN;
                end
            end
            SPAWN: begin
                stateNext = FALL;
            end
            FALL: begin
                if (spawnBlocked) begin         // New piece overlaps the stack
                    stateNext = OVER;
                end else if (landed) begin
                    stateNext = LOCK;
                end
            end
            LOCK: begin
                stateNext = CLEAR;
            end
            CLEAR: begin
                if (!anyFull) begin
                    stateNext = SPAWN;          // One row removed per cycle until none
                end
            end
            OVER: begin
                stateNext = OVER;               // Held until reset
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
    end

    assign spawn     = (state == SPAWN);
    assign fallEn    = (state == FALL);
    assign lock      = (state == LOCK);
    assign clearEn   = (state == CLEAR) && anyFull;
    assign pieceDone = (state == CLEAR) && !anyFull;
    assign gameOver  = (state == OVER);

endmodule

// ==== hdl/pieceDrop.sv ====
`include "tetris_defs.svh"

module pieceDrop (
    input  logic             clk,
    input  logic             rst,
    input  logic             spawn,
    input  logic             fallEn,
    input  logic             step,
    input  logic             left,
    input  logic             right,
    input  tetrisPkg::pieceT nextPiece,
    input  tetrisPkg::boardT board,
    output tetrisPkg::boardT pieceMask,
    output tetrisPkg::pieceT curPiece,
    output logic             landed,
    output logic             spawnBlocked
);

    import tetrisPkg::*;

    rowIdxT blockY;
    colIdxT blockX;
    pieceT  kind;
    logic   active;     // A piece is on the field
    boardT  curMask;
    boardT  downMask;
    boardT  leftMask;
    boardT  rightMask;
    logic   downFits;
    logic   leftFits;
    logic   rightFits;
    logic   downLegal;
    logic   leftLegal;
    logic   rightLegal;
    logic   moveOk;

    // Draws one shape at anchor (y, x); returns 0 if any cell leaves the field
    function automatic logic drawShape(input int y, input int x, input pieceT k,
                                       output boardT m);
        logic [3:0][1:0] dy;
        logic [3:0][1:0] dx;    // Column offset plus one
        int r;
        int c;
        logic fits;
        m = '0;
        fits = 1'b1;
        case (k)
            SQUARE: begin
                dy = {2'd1, 2'd1, 2'd0, 2'd0};
                dx = {2'd2, 2'd1, 2'd2, 2'd1};
            end
            L: begin
                dy = {2'd2, 2'd2, 2'd1, 2'd0};
                dx = {2'd2, 2'd1, 2'd1, 2'd1};
            end
            REVL: begin
                dy = {2'd2, 2'd2, 2'd1, 2'd0};
                dx = {2'd1, 2'd2, 2'd2, 2'd2};
            end
            S: begin
                dy = {2'd1, 2'd1, 2'd0, 2'd0};
                dx = {2'd2, 2'd1, 2'd3, 2'd2};
            end
            Z: begin
                dy = {2'd1, 2'd1, 2'd0, 2'd0};
                dx = {2'd3, 2'd2, 2'd2, 2'd1};
            end
            T: begin
                dy = {2'd1, 2'd1, 2'd1, 2'd0};
                dx = {2'd2, 2'd1, 2'd0, 2'd1};    // Stem on top, bar below
            end
            default: begin                         // LINE
                dy = {2'd3, 2'd2, 2'd1, 2'd0};
                dx = {2'd1, 2'd1, 2'd1, 2'd1};
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            r = y + int'(dy[i]);
            c = x + int'(dx[i]) - 1;
            if (r >= 0 && r < `BOARD_ROWS && c >= 0 && c < `BOARD_COLS) begin
                m[rowIdxT'(r)][colIdxT'(c)] = 1'b1;
            end else begin
                fits = 1'b0;
            end
        end
        return fits;
    endfunction

    always_comb begin
        void'(drawShape(int'(blockY), int'(blockX), kind, curMask));
        downFits  = drawShape(int'(blockY) + 1, int'(blockX), kind, downMask);
        leftFits  = drawShape(int'(blockY), int'(blockX) - 1, kind, leftMask);
        rightFits = drawShape(int'(blockY), int'(blockX) + 1, kind, rightMask);
    end

    // Candidate is legal when inside the field and clear of the stack
    assign downLegal  = downFits && ((downMask & board) == '0);
    assign leftLegal  = leftFits && ((leftMask & board) == '0);
    assign rightLegal = rightFits && ((rightMask & board) == '0);

    assign pieceMask    = active ? curMask : '0;
    assign curPiece     = kind;
    assign spawnBlocked = (pieceMask & board) != '0;
    assign moveOk       = fallEn && !spawnBlocked;
    assign landed       = moveOk && step && !downLegal;  // Stack or floor below

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            blockY <= '0;
            blockX <= colIdxT'(`SPAWN_COL);
            kind   <= LINE;
            active <= 1'b0;
        end else if (spawn) begin
            blockY <= '0;
            blockX <= colIdxT'(`SPAWN_COL);
            kind   <= nextPiece;
            active <= 1'b1;
        end else if (moveOk) begin
            if (step) begin                 // Step wins over a sideways move
                if (downLegal) begin
                    blockY <= blockY + rowIdxT'(1);
                end
            end else if (left && leftLegal) begin
                blockX <= blockX - colIdxT'(1);
            end else if (right && rightLegal) begin
                blockX <= blockX + colIdxT'(1);
            end
        end
    end

endmodule

// ==== hdl/pieceSelect.sv ====
`include "tetris_defs.svh"

module pieceSelect (
    input  logic            clk,
    input  logic            rst,
    input  logic            spawn,
    output tetrisPkg::pieceT nextPiece
);

    import tetrisPkg::*;

    logic [7:0] lfsr;
    logic       feedback;

    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];  // Taps 8, 6, 5, 4

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lfsr <= `PIECE_SEED;
        end else if (spawn) begin
            lfsr <= {lfsr[6:0], feedback};  // Advance once per spawn
        end
    end

    // Code 7 has no shape and folds onto LINE
    always_comb begin
        if (lfsr[2:0] == 3'd7) begin
            nextPiece = LINE;
        end else begin
            nextPiece = pieceT'(lfsr[2:0]);
        end
    end

endmodule

// ==== hdl/tetrisCore.sv ====
module tetrisCore (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               step,
    input  logic               left,
    input  logic               right,
    output tetrisPkg::boardT   board,
    output tetrisPkg::boardT   pieceMask,
    output tetrisPkg::pieceT   curPiece,
    output tetrisPkg::lineCntT lines,
    output logic               pieceDone,
    output logic               gameOver
);

    import tetrisPkg::*;

    logic  spawn;
    logic  fallEn;
    logic  lock;
    logic  clearEn;
    logic  landed;
    logic  spawnBlocked;
    logic  anyFull;
    pieceT nextPiece;

    gameControl control_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .landed      (landed),
        .spawnBlocked(spawnBlocked),
        .anyFull     (anyFull),
        .spawn       (spawn),
        .fallEn      (fallEn),
        .lock        (lock),
        .clearEn     (clearEn),
        .pieceDone   (pieceDone),
        .gameOver    (gameOver)
    );

    pieceSelect select_i (
        .clk      (clk),
        .rst      (rst),
        .spawn    (spawn),
        .nextPiece(nextPiece)
    );

    pieceDrop drop_i (
        .clk         (clk),
        .rst         (rst),
        .spawn       (spawn),
        .fallEn      (fallEn),
        .step        (step),
        .left        (left),
        .right       (right),
        .nextPiece   (nextPiece),
        .board       (board),
        .pieceMask   (pieceMask),
        .curPiece    (curPiece),
        .landed      (landed),
        .spawnBlocked(spawnBlocked)
    );

    boardStore store_i (
        .clk      (clk),
        .rst      (rst),
        .lock     (lock),
        .clearEn  (clearEn),
        .pieceMask(pieceMask),
        .board    (board),
        .anyFull  (anyFull),
        .lines    (lines)
    );

endmodule

// ==== hdl/tetrisPkg.sv ====
`include "tetris_defs.svh"

package tetrisPkg;

    typedef logic [`BOARD_COLS-1:0] rowT;        // One bit per column
    typedef rowT [`BOARD_ROWS-1:0] boardT;       // Row 0 is the top row
    typedef logic [4:0] rowIdxT;
    typedef logic [3:0] colIdxT;
    typedef logic [`LINE_W-1:0] lineCntT;

    typedef enum logic [2:0] {
        LINE   = 3'd0,
        SQUARE = 3'd1,
        L      = 3'd2,
        REVL   = 3'd3,
        S      = 3'd4,
        Z      = 3'd5,
        T      = 3'd6
    } pieceT;

    typedef enum logic [2:0] {
        IDLE,
        SPAWN,
        FALL,
        LOCK,
        CLEAR,
        OVER
    } gameStateT;

endpackage

// ==== hdl/tetris_defs.svh ====
`ifndef TETRIS_DEFS_SVH
`define TETRIS_DEFS_SVH

// Playfield size in cells
`define BOARD_ROWS 20
`define BOARD_COLS 10

// Anchor column of a freshly spawned piece
`define SPAWN_COL 4

// Reset value of the piece chooser LFSR
`define PIECE_SEED 8'h5A

// Width of the cleared-line counter
`define LINE_W 16

`endif

// ==== runSim.sh ====
#!/bin/sh
# Builds the tetrisCore testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tetrisCore_tb -f tetris.f -o simTetris
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Assertion errors must not stop the run before the final report
./obj_dir/simTetris +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tetris.f ====
+incdir+hdl
hdl/tetrisPkg.sv
hdl/pieceSelect.sv
hdl/pieceDrop.sv
hdl/boardStore.sv
hdl/gameControl.sv
hdl/tetrisCore.sv
verification/tetrisCore_sva.sv
verification/tetrisCore_tb.sv

// ==== verification/tetrisCore_sva.sv ====
module tetrisCore_sva (
    input logic               clk,
    input logic               rst,
    input logic               spawn,
    input logic               fallEn,
    input logic               lock,
    input logic               clearEn,
    input logic               pieceDone,
    input logic               gameOver,
    input tetrisPkg::boardT   board,
    input tetrisPkg::boardT   pieceMask,
    input tetrisPkg::lineCntT lines
);

    timeunit 1ns;
    timeprecision 1ps;

    int assertFails = 0;    // Read by the testbench at the end

    strobeOneHot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({spawn, fallEn, lock, clearEn, pieceDone}))
        else begin
            assertFails++;
            $error("more than one control strobe high");
        end

    overHeld: assert property (@(posedge clk) disable iff (rst) gameOver |=> gameOver)
        else begin
            assertFails++;
            $error("gameOver fell without reset");
        end

    // First FALL cycle after a spawn is the overlap check itself
    noOverlap: assert property (@(posedge clk) disable iff (rst)
        fallEn && !$past(spawn) |-> (pieceMask & board) == '0)
        else begin
            assertFails++;
            $error("falling piece overlaps the settled cells");
        end

    linesRise: assert property (@(posedge clk) disable iff (rst) lines >= $past(lines))
        else begin
            assertFails++;
            $error("line count decreased");
        end

endmodule

bind tetrisCore tetrisCore_sva sva_i (.*);

// ==== verification/tetrisCore_tb.sv ====
`include "tetris_defs.svh"

module tetrisCore_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import tetrisPkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int START_CYCLES = 4;    // Reset values, start, SPAWN, first piece
    localparam int FALL_CYCLES  = 300;
    localparam int LOCK_CYCLES  = 800;
    localparam int CLEAR_CYCLES = 1500;
    localparam int OVER_CYCLES  = 1500;
    localparam int AFTER_CYCLES = 40;   // Pulses once the game is over
    localparam int PLAN_CYCLES  = RESET_CYCLES + START_CYCLES + FALL_CYCLES + LOCK_CYCLES +
                                  CLEAR_CYCLES + OVER_CYCLES + AFTER_CYCLES;

    logic    clk;
    logic    rst;
    logic    start;
    logic    step;
    logic    left;
    logic    right;
    boardT   board;
    boardT   pieceMask;
    pieceT   curPiece;
    lineCntT lines;
    logic    pieceDone;
    logic    gameOver;

    logic [15:0] stim;          // Stimulus LFSR
    gameStateT   mState;        // Reference game model
    int          mY;
    int          mX;
    int          mTarget;       // Column goal for spread play
    pieceT       mKind;
    logic        mActive;
    boardT       mBoard;
    lineCntT     mLines;
    logic [7:0]  mSel;          // Model of the piece chooser
    int          piecesDone;
    int          checks;
    int          errors;
    int          testsRun;
    int          testsFailed;
    int          errMark;
    int          pieceMark;
    int          lineMark;

    tetrisCore dut_i (.*);

    always #10 clk = ~clk;

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16, 14, 13, 11
    endfunction

    function automatic int randBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            stim = lfsrNext(stim);
            v = (v << 1) | int'(stim[0]);
        end
        return v;
    endfunction

    function automatic pieceT chooserKind(input logic [7:0] s);
        return (s[2:0] == 3'd7) ? LINE : pieceT'(s[2:0]);
    endfunction

    // Draws a shape into m; true when it is on the field and clear of b
    function automatic logic placeOk(input int y, input int x, input pieceT k,
                                     input boardT b, output boardT m);
        int dr[4];
        int dc[4];
        int r;
        int c;
        logic ok;
        case (k)
            SQUARE: dr = '{0, 0, 1, 1};
            L:      dr = '{0, 1, 2, 2};
            REVL:   dr = '{0, 1, 2, 2};
            S:      dr = '{0, 0, 1, 1};
            Z:      dr = '{0, 0, 1, 1};
            T:      dr = '{0, 1, 1, 1};
            default: dr = '{0, 1, 2, 3};
        endcase
        case (k)
            SQUARE: dc = '{0, 1, 0, 1};
            L:      dc = '{0, 0, 0, 1};
            REVL:   dc = '{1, 1, 1, 0};
            S:      dc = '{1, 2, 0, 1};
            Z:      dc = '{0, 1, 1, 2};
            T:      dc = '{0, -1, 0, 1};
            default: dc = '{0, 0, 0, 0};
        endcase
        m = '0;
        ok = 1'b1;
        for (int i = 0; i < 4; i++) begin
            r = y + dr[i];
            c = x + dc[i];
            if (r >= 0 && r < `BOARD_ROWS && c >= 0 && c < `BOARD_COLS) begin
                m[r][c] = 1'b1;
            end else begin
                ok = 1'b0;
            end
        end
        return ok && ((m & b) == '0);
    endfunction

    function automatic int lowestFull(input boardT b);
        for (int r = `BOARD_ROWS - 1; r >= 0; r--) begin
            if (b[r] == '1) begin
                return r;
            end
        end
        return -1;
    endfunction

    // Next model state for the inputs seen at the coming rising edge
    task automatic advanceModel(input logic st, input logic lf, input logic rt,
                                input logic sta);
        boardT m;
        int r;
        case (mState)
            IDLE: begin
                if (sta) begin
                    mState = SPAWN;
                end
            end
            SPAWN: begin
                mY = 0;
                mX = `SPAWN_COL;
                mKind = chooserKind(mSel);
                mSel = {mSel[6:0], mSel[7] ^ mSel[5] ^ mSel[4] ^ mSel[3]};
                mActive = 1'b1;
                mState = FALL;
            end
            FALL: begin
                if (!placeOk(mY, mX, mKind, mBoard, m)) begin
                    mState = OVER;              // Spawned onto the stack
                end else if (st) begin
                    if (placeOk(mY + 1, mX, mKind, mBoard, m)) begin
                        mY++;
                    end else begin
                        mState = LOCK;
                    end
                end else if (lf && placeOk(mY, mX - 1, mKind, mBoard, m)) begin
                    mX--;
                end else if (rt && placeOk(mY, mX + 1, mKind, mBoard, m)) begin
                    mX++;
                end
            end
            LOCK: begin
                void'(placeOk(mY, mX, mKind, '0, m));
                mBoard = mBoard | m;
                mState = CLEAR;
            end
            CLEAR: begin
                r = lowestFull(mBoard);
                if (r < 0) begin
                    piecesDone++;
                    mState = SPAWN;
                end else begin
                    for (int i = r; i > 0; i--) begin
                        mBoard[i] = mBoard[i - 1];
                    end
                    mBoard[0] = '0;
                    mLines++;
                end
            end
            default: begin                      // OVER holds until reset
            end
        endcase
    endtask

    task automatic checkBoard(input string name, input boardT got, input boardT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic checkPiece(input string name, input pieceT got, input pieceT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic checkLines(input string name, input lineCntT got, input lineCntT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic compareAll();
        boardT m;
        m = '0;
        if (mActive) begin
            void'(placeOk(mY, mX, mKind, '0, m));
        end
        checkBoard("board", board, mBoard);
        checkBoard("pieceMask", pieceMask, m);
        checkPiece("curPiece", curPiece, mKind);
        checkLines("lines", lines, mLines);
        checkFlag("pieceDone", pieceDone, mState == CLEAR && lowestFull(mBoard) < 0);
        checkFlag("gameOver", gameOver, mState == OVER);
    endtask

    // Mode 0 idle, 1 random pulses, 2 spread across columns, 3 steps only
    task automatic runCycle(input int mode, input logic doStart);
        logic st;
        logic lf;
        logic rt;
        int r;
        @(negedge clk);
        compareAll();
        st = 1'b0;
        lf = 1'b0;
        rt = 1'b0;
        if (mState == SPAWN) begin
            mTarget = randBits(4) % 10;
        end
        if (mode == 1) begin
            r = randBits(3);
            st = (r == 2 || r == 3 || r >= 6);
            lf = (r == 4 || r == 6);                // 6 and 7 pair a move with a step
            rt = (r == 5 || r == 7);
        end else if (mode == 2) begin
            r = randBits(2);
            st = (r == 0) || (mX == mTarget);       // Occasional step frees a stuck piece
            lf = !st && (mX > mTarget);
            rt = !st && (mX < mTarget);
        end else if (mode == 3) begin
            st = 1'b1;
        end
        start = doStart;
        step = st;
        left = lf;
        right = rt;
        advanceModel(st, lf, rt, doStart);
    endtask

    task automatic runPhase(input int mode, input int maxCycles, input int pieceGoal);
        int n;
        n = 0;
        while (n < maxCycles && mState != OVER &&
               (pieceGoal == 0 || piecesDone - pieceMark < pieceGoal)) begin
            runCycle(mode, 1'b0);
            n++;
        end
    endtask

    task automatic markTest();
        errMark = errors;
        pieceMark = piecesDone;
        lineMark = int'(mLines);
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        if (errors != errMark) begin
            testsFailed++;
        end
        $display("test %0d %s: %s, %0d pieces, %0d lines, %0d errors", testsRun, name,
                 (errors == errMark) ? "ok" : "FAIL", piecesDone - pieceMark,
                 int'(mLines) - lineMark, errors - errMark);
    endtask

    initial begin
        #(PLAN_CYCLES * 20 * 2);
        $display("watchdog expired after %0d cycles with the run unfinished", PLAN_CYCLES * 2);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        step = 1'b0;
        left = 1'b0;
        right = 1'b0;
        stim = 16'd26;
        mState = IDLE;
        mY = 0;
        mX = `SPAWN_COL;
        mTarget = 0;
        mKind = LINE;
        mActive = 1'b0;
        mBoard = '0;
        mLines = '0;
        mSel = `PIECE_SEED;
        piecesDone = 0;
        checks = 0;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        markTest();
        runCycle(0, 1'b0);                  // Values right after reset
        runCycle(0, 1'b1);
        runCycle(0, 1'b0);                  // SPAWN
        runCycle(0, 1'b0);                  // First piece from the seed
        reportTest("reset and start");

        markTest();
        runPhase(1, FALL_CYCLES, 0);
        reportTest("falling and moving");

        markTest();
        runPhase(1, LOCK_CYCLES, 6);
        reportTest("locking");

        markTest();
        runPhase(2, CLEAR_CYCLES, 0);
        reportTest("row clearing");

        markTest();
        runPhase(3, OVER_CYCLES, 0);
        if (mState != OVER) begin
            errors++;
            $display("stack never reached the spawn position within %0d cycles", OVER_CYCLES);
        end
        repeat (AFTER_CYCLES) runCycle(1, 1'b0);    // Pulses after game over change nothing
        reportTest("game over");

        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 testsRun, testsFailed, checks, errors, dut_i.sva_i.assertFails);
        if (errors == 0 && dut_i.sva_i.assertFails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
